/* build.f */
hdl/nnPkg.sv
hdl/floatMult.sv
hdl/floatAdd.sv
hdl/reluNode.sv
hdl/mlpCore.sv
verif/mlpCoreAssert_assert.sv
verif/mlpCoreTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module mlpCoreTb \
		-f build.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/mlpCoreTb.sv */
`timescale 1ns/1ns

module mlpCoreTb;
	localparam int clkPeriod = 100;
	localparam int driveDelay = 10;
	localparam int resetCycles = 5;
	localparam int clampCount = 5;
	localparam int streamCycles = 40;
	localparam int alignCount = 6;
	localparam int vectorTotal = nnPkg::featureCount + clampCount + streamCycles + alignCount;
	localparam int marginCycles = 30; // reset tail, drains and slack.
	localparam int watchdogTime = (vectorTotal + resetCycles + marginCycles) * clkPeriod;

	logic clk;
	logic rstN;
	logic [31:0] feature [0:nnPkg::featureCount-1];
	logic [31:0] score0;
	logic [31:0] score1;

	int vec [0:nnPkg::featureCount-1];
	logic [31:0] expPipe0 [0:1];
	logic [31:0] expPipe1 [0:1];
	bit validPipe [0:1];
	int errorCount;
	int checkCount;
	int testCount;

	mlpCore i_mlpCore (
		.clk(clk),
		.rstN(rstN),
		.feature0(feature[0]),
		.feature1(feature[1]),
		.feature2(feature[2]),
		.feature3(feature[3]),
		.feature4(feature[4]),
		.feature5(feature[5]),
		.feature6(feature[6]),
		.feature7(feature[7]),
		.score0(score0),
		.score1(score1)
	);

	bind mlpCore mlpCoreAssert i_mlpCoreAssert (
		.clk(clk),
		.rstN(rstN),
		.score0(score0),
		.score1(score1)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(watchdogTime);
		$display("Timeout: run did not finish within %0d ns", watchdogTime);
		$display("Simulation FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model in real arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic real floatToReal(input logic [31:0] w);
		nnPkg::fpWord f;
		logic [63:0] d;
		f.bits = w;
		if (f.fields.exponent == 8'd0)
			return 0.0;
		d = {f.fields.sign, 11'(f.fields.exponent) + 11'(1023 - nnPkg::expBias),
			f.fields.fraction, 29'd0}; // widen to double.
		return $bitstoreal(d);
	endfunction

	function automatic logic [31:0] realToFloat(input real r);
		logic [63:0] d;
		nnPkg::fpWord f;
		if (r == 0.0)
			return 32'd0; // -0 too.
		d = $realtobits(r);
		f.fields.sign = d[63];
		f.fields.exponent = 8'(d[62:52] - 11'(1023 - nnPkg::expBias));
		f.fields.fraction = d[51:29]; // exact, no rounding needed.
		return f.bits;
	endfunction

	function automatic real relu(input real x);
		return (x > 0.0) ? x : 0.0;
	endfunction

	function automatic void modelScores(output logic [31:0] exp0, output logic [31:0] exp1);
		real hidden [0:nnPkg::hiddenCount-1];
		real score [0:nnPkg::outCount-1];
		real acc;
		for (int h = 0; h < nnPkg::hiddenCount; h++)
		begin
			acc = floatToReal(nnPkg::hiddenBias[h]);
			for (int f = 0; f < nnPkg::featureCount; f++)
				acc += floatToReal(nnPkg::hiddenWeight[h][f]) * real'(vec[f]);
			hidden[h] = relu(acc);
		end
		for (int o = 0; o < nnPkg::outCount; o++)
		begin
			acc = floatToReal(nnPkg::outBias[o]);
			for (int h = 0; h < nnPkg::hiddenCount; h++)
				acc += floatToReal(nnPkg::outWeight[o][h]) * hidden[h];
			score[o] = relu(acc);
		end
		exp0 = realToFloat(score[0]);
		exp1 = realToFloat(score[1]);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic checkWord(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Mismatch %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic setVector(input int v0, input int v1, input int v2, input int v3,
		input int v4, input int v5, input int v6, input int v7);
		vec[0] = v0;
		vec[1] = v1;
		vec[2] = v2;
		vec[3] = v3;
		vec[4] = v4;
		vec[5] = v5;
		vec[6] = v6;
		vec[7] = v7;
	endtask

	// one clock, checking the vector sent two cycles back.
	task automatic stepCycle(input bit send);
		@(posedge clk);
		#(driveDelay);
		if (validPipe[1])
		begin
			checkWord("score0", score0, expPipe0[1]);
			checkWord("score1", score1, expPipe1[1]);
		end
		validPipe[1] = validPipe[0];
		expPipe0[1] = expPipe0[0];
		expPipe1[1] = expPipe1[0];
		validPipe[0] = send;
		if (send)
		begin
			for (int i = 0; i < nnPkg::featureCount; i++)
				feature[i] = realToFloat(real'(vec[i]));
			modelScores(expPipe0[0], expPipe1[0]);
		end
	endtask

	task automatic drainPipe();
		stepCycle(1'b0);
		stepCycle(1'b0);
	endtask

	task automatic reportTest(input string name, input int errStart);
		testCount++;
		$display("%-16s done, %0d errors", name, errorCount - errStart);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic resetTest();
		int errStart;
		errStart = errorCount;
		#(driveDelay);
		rstN = 1'b0;
		repeat (resetCycles)
		begin
			@(posedge clk);
			#(driveDelay);
			checkWord("score0", score0, 32'd0);
			checkWord("score1", score1, 32'd0);
		end
		rstN = 1'b1;
		#(clkPeriod - 2 * driveDelay); // just before the first edge.
		checkWord("score0", score0, 32'd0);
		checkWord("score1", score1, 32'd0);
		// hidden still zero, so scores are relu of the bias.
		@(posedge clk);
		#(driveDelay);
		checkWord("score0", score0, realToFloat(relu(floatToReal(nnPkg::outBias[0]))));
		checkWord("score1", score1, realToFloat(relu(floatToReal(nnPkg::outBias[1]))));
		reportTest("reset", errStart);
	endtask

	task automatic singleFeatureTest();
		int errStart;
		errStart = errorCount;
		for (int i = 0; i < nnPkg::featureCount; i++)
		begin
			setVector(0, 0, 0, 0, 0, 0, 0, 0);
			vec[i] = 1;
			stepCycle(1'b1);
		end
		drainPipe();
		reportTest("single feature", errStart);
	endtask

	task automatic negativeClampTest();
		int errStart;
		errStart = errorCount;
		setVector(-8, -8, -8, -8, -8, -8, -8, -8); // all hidden clamp.
		stepCycle(1'b1);
		setVector(0, 8, 0, 0, 0, 0, 0, 0); // score0 sum negative.
		stepCycle(1'b1);
		setVector(8, 0, 0, 0, 0, 0, 0, 0); // score1 sum negative.
		stepCycle(1'b1);
		setVector(-8, 8, -8, 8, -8, 8, -8, 8);
		stepCycle(1'b1);
		setVector(0, 0, -3, 0, 5, 0, 7, -2);
		stepCycle(1'b1);
		drainPipe();
		reportTest("negative clamp", errStart);
	endtask

	task automatic streamTest();
		int errStart;
		errStart = errorCount;
		for (int c = 0; c < streamCycles; c++)
		begin
			for (int i = 0; i < nnPkg::featureCount; i++)
				vec[i] = int'($urandom_range(16)) - 8;
			stepCycle(1'b1);
		end
		drainPipe();
		reportTest("streaming", errStart);
	endtask

	task automatic alignTest();
		int errStart;
		errStart = errorCount;
		setVector(4096, 1, 0, 0, 0, 0, 0, 0);
		stepCycle(1'b1);
		setVector(1, 0, 0, 0, 0, 0, 0, 4096);
		stepCycle(1'b1);
		setVector(-8192, 0, 4096, 0, 0, 0, 0, 0); // hidden0 products cancel.
		stepCycle(1'b1);
		setVector(0, 4096, 0, 0, 0, 0, 0, -3);
		stepCycle(1'b1);
		setVector(4096, -4096, 4096, -4096, 1, -1, 1, -1);
		stepCycle(1'b1);
		setVector(16384, 0, 0, 0, 0, 0, 0, 1);
		stepCycle(1'b1);
		drainPipe();
		reportTest("alignment", errStart);
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		rstN = 1'b1;
		for (int i = 0; i < nnPkg::featureCount; i++)
		begin
			feature[i] = 32'd0;
			vec[i] = 0;
		end
		for (int i = 0; i < 2; i++)
		begin
			validPipe[i] = 1'b0;
			expPipe0[i] = 32'd0;
			expPipe1[i] = 32'd0;
		end
		void'($urandom(32'h286b_c735));

		resetTest();
		singleFeatureTest();
		negativeClampTest();
		streamTest();
		alignTest();

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verif/mlpCoreAssert_assert.sv */
`timescale 1ns/1ns

module mlpCoreAssert (
	input logic clk,
	input logic rstN,
	input logic [31:0] score0,
	input logic [31:0] score1
);
	nnPkg::fpWord s0;
	nnPkg::fpWord s1;

	assign s0.bits = score0;
	assign s1.bits = score1;

	// relu output is never negative.
	signClear: assert property (@(posedge clk) !s0.fields.sign && !s1.fields.sign)
		else $error("score sign bit set, score0 %h score1 %h", score0, score1);

	// saturation keeps the exponent below the reserved value.
	expInRange: assert property (@(posedge clk)
		(s0.fields.exponent != 8'(nnPkg::expMax)) && (s1.fields.exponent != 8'(nnPkg::expMax)))
		else $error("score exponent reserved, score0 %h score1 %h", score0, score1);

	zeroInReset: assert property (@(posedge clk)
		!rstN |-> (score0 == 32'd0 && score1 == 32'd0))
		else $error("score not zero in reset, score0 %h score1 %h", score0, score1);

endmodule

/* hdl/mlpCore.sv */
`timescale 1ns/1ns

module mlpCore (
	input logic clk,
	input logic rstN,
	input logic [31:0] feature0,
	input logic [31:0] feature1,
	input logic [31:0] feature2,
	input logic [31:0] feature3,
	input logic [31:0] feature4,
	input logic [31:0] feature5,
	input logic [31:0] feature6,
	input logic [31:0] feature7,
	output logic [31:0] score0,
	output logic [31:0] score1
);
	logic [nnPkg::featureCount*32-1:0] featureBus;
	logic [nnPkg::hiddenCount*32-1:0] hiddenBus;
	logic [nnPkg::outCount*32-1:0] scoreBus;

	assign featureBus = {feature7, feature6, feature5, feature4,
		feature3, feature2, feature1, feature0}; // feature0 in the low word.

	for (genvar h = 0; h < nnPkg::hiddenCount; h++)
	begin : gHidden
		reluNode #(
			.fanIn(nnPkg::featureCount),
			.weights(nnPkg::hiddenWeight[h]),
			.bias(nnPkg::hiddenBias[h])
		) i_hidden (
			.clk(clk),
			.rstN(rstN),
			.act(featureBus),
			.out(hiddenBus[h*32 +: 32])
		);
	end

	for (genvar o = 0; o < nnPkg::outCount; o++)
	begin : gOut
		reluNode #(
			.fanIn(nnPkg::hiddenCount),
			.weights(nnPkg::outWeight[o]),
			.bias(nnPkg::outBias[o])
		) i_out (
			.clk(clk),
			.rstN(rstN),
			.act(hiddenBus),
			.out(scoreBus[o*32 +: 32])
		);
	end

	assign score0 = scoreBus[31:0];
	assign score1 = scoreBus[63:32];

endmodule

/* hdl/reluNode.sv */
`timescale 1ns/1ns

module reluNode #(
	parameter int fanIn = 8,
	parameter logic [0:fanIn-1][31:0] weights = '0,
	parameter logic [31:0] bias = 32'd0
) (
	input logic clk,
	input logic rstN,
	input logic [fanIn*32-1:0] act,
	output logic [31:0] out
);
	// products plus bias, padded up to a power of two.
	localparam int leafCount = fanIn + 1;
	localparam int levels = $clog2(leafCount);
	localparam int padCount = 1 << levels;
	localparam int nodeCount = 2 * padCount - 1;

	// heap order, node n adds nodes 2n+1 and 2n+2.
	logic [31:0] tree [0:nodeCount-1];
	nnPkg::fpWord sumWord;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// leaves
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < padCount; i++)
	begin : gLeaf
		if (i < fanIn)
		begin : gMult
			floatMult i_mult (
				.a(act[i*32 +: 32]),
				.b(weights[i]),
				.product(tree[padCount-1+i])
			);
		end
		else if (i == fanIn)
		begin : gBias
			assign tree[padCount-1+i] = bias; // first leaf after the products.
		end
		else
		begin : gPad
			assign tree[padCount-1+i] = 32'd0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// adder tree
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar n = 0; n < padCount - 1; n++)
	begin : gAdd
		floatAdd i_add (
			.a(tree[2*n+1]),
			.b(tree[2*n+2]),
			.sum(tree[n])
		);
	end

	assign sumWord.bits = tree[0];

	// relu register.
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			out <= 32'd0;
		else if (sumWord.fields.sign)
			out <= 32'd0; // also catches -0.
		else
			out <= sumWord.bits;
	end

endmodule

/* hdl/floatAdd.sv */
`timescale 1ns/1ns

module floatAdd (
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] sum
);
	nnPkg::fpWord big;
	nnPkg::fpWord smallOp;
	nnPkg::fpWord res;
	logic swap;
	logic [23:0] mantBig;
	logic [23:0] mantSmall;
	logic [7:0] expDiff;
	logic [5:0] shiftAmt;
	logic [49:0] alignWide;
	logic [26:0] extBig;
	logic [26:0] extSmall;
	logic effSub;
	logic [27:0] magSum;
	logic [4:0] lzCount;
	logic [26:0] normM;
	logic signed [9:0] expRes;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [24:0] mantRound;

	function automatic logic [4:0] leadZeros(input logic [26:0] v);
		logic [4:0] count;
		logic seen;
		count = 5'd0;
		seen = 1'b0;
		for (int i = 26; i >= 0; i--)
		begin
			if (v[i])
				seen = 1'b1;
			else if (!seen)
				count = count + 5'd1;
		end
		return count;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// order and align
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign swap = b[30:0] > a[30:0];
	assign big.bits = swap ? b : a;
	assign smallOp.bits = swap ? a : b;

	// zero exponent flushes the operand.
	assign mantBig = (big.fields.exponent == 8'd0) ? 24'd0 : {1'b1, big.fields.fraction};
	assign mantSmall = (smallOp.fields.exponent == 8'd0) ? 24'd0
		: {1'b1, smallOp.fields.fraction};

	assign expDiff = big.fields.exponent - smallOp.fields.exponent;
	assign shiftAmt = (expDiff > 8'd49) ? 6'd49 : expDiff[5:0];
	assign alignWide = {mantSmall, 26'd0} >> shiftAmt;
	assign extSmall = {alignWide[49:24], |alignWide[23:0]}; // guard, round, sticky.
	assign extBig = {mantBig, 3'b000};

	assign effSub = big.fields.sign ^ smallOp.fields.sign;
	assign magSum = effSub ? {1'b0, extBig} - {1'b0, extSmall}
		: {1'b0, extBig} + {1'b0, extSmall};
	assign lzCount = leadZeros(magSum[26:0]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// normalize and round
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		if (magSum[27]) // carry out of the add.
		begin
			normM = {magSum[27:2], |magSum[1:0]};
			expRes = $signed({2'b00, big.fields.exponent}) + 10'sd1;
		end
		else
		begin
			normM = magSum[26:0] << lzCount;
			expRes = $signed({2'b00, big.fields.exponent}) - $signed({5'd0, lzCount});
		end
		guardBit = normM[2];
		stickyBit = |normM[1:0];
		roundUp = guardBit & (stickyBit | normM[3]);
		mantRound = {1'b0, normM[26:3]} + {24'd0, roundUp};
		if (mantRound[24])
			expRes = expRes + 10'sd1;

		if (magSum == 28'd0 || expRes <= 10'sd0)
			res.bits = 32'd0; // cancellation gives +0.
		else if (expRes >= $signed(10'(nnPkg::expMax)))
		begin
			res.bits = nnPkg::fpMaxFinite;
			res.fields.sign = big.fields.sign;
		end
		else
		begin
			res.fields.sign = big.fields.sign;
			res.fields.exponent = expRes[7:0];
			res.fields.fraction = mantRound[24] ? mantRound[23:1] : mantRound[22:0];
		end
	end

	assign sum = res.bits;

endmodule

/* hdl/floatMult.sv */
`timescale 1ns/1ns

module floatMult (
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] product
);
	nnPkg::fpWord opA;
	nnPkg::fpWord opB;
	nnPkg::fpWord res;
	logic resSign;
	logic anyZero;
	logic [47:0] mantProd;
	logic [23:0] mantNorm;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [24:0] mantRound;
	logic signed [10:0] expRes;

	assign opA.bits = a;
	assign opB.bits = b;
	assign resSign = opA.fields.sign ^ opB.fields.sign;
	assign anyZero = (opA.fields.exponent == 8'd0) || (opB.fields.exponent == 8'd0); // subnormals too.
	assign mantProd = {1'b1, opA.fields.fraction} * {1'b1, opB.fields.fraction};

	always_comb
	begin
		expRes = $signed({3'b000, opA.fields.exponent}) + $signed({3'b000, opB.fields.exponent})
			- $signed(11'(nnPkg::expBias));
		if (mantProd[47]) // product in [2,4).
		begin
			mantNorm = mantProd[47:24];
			guardBit = mantProd[23];
			stickyBit = |mantProd[22:0];
			expRes = expRes + 11'sd1;
		end
		else
		begin
			mantNorm = mantProd[46:23];
			guardBit = mantProd[22];
			stickyBit = |mantProd[21:0];
		end
		roundUp = guardBit & (stickyBit | mantNorm[0]); // nearest even.
		mantRound = {1'b0, mantNorm} + {24'd0, roundUp};
		if (mantRound[24])
			expRes = expRes + 11'sd1;

		if (anyZero || expRes <= 11'sd0)
			res.bits = 32'd0;
		else if (expRes >= $signed(11'(nnPkg::expMax)))
		begin
			res.bits = nnPkg::fpMaxFinite;
			res.fields.sign = resSign;
		end
		else
		begin
			res.fields.sign = resSign;
			res.fields.exponent = expRes[7:0];
			res.fields.fraction = mantRound[24] ? mantRound[23:1] : mantRound[22:0];
		end
	end

	assign product = res.bits;

endmodule

/* hdl/nnPkg.sv */
package nnPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// single precision word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] fraction;
	} fpFields;

	typedef union packed
	{
		logic [31:0] bits;
		fpFields fields;
	} fpWord;

	localparam int expBias = 127;
	localparam int expMax = 255; // reserved for inf and nan.
	localparam logic [31:0] fpMaxFinite = 32'h7f7f_ffff;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// network shape
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int featureCount = 8;
	localparam int hiddenCount = 4;
	localparam int outCount = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// weights and biases, index 0 first in each row
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [0:hiddenCount-1][0:featureCount-1][31:0] hiddenWeight = {
		{ // 0.5 -0.25 1.0 0.75 -1.25 0.375 0.125 -0.5.
			32'h3f00_0000, 32'hbe80_0000, 32'h3f80_0000, 32'h3f40_0000,
			32'hbfa0_0000, 32'h3ec0_0000, 32'h3e00_0000, 32'hbf00_0000
		},
		{ // -0.75 1.5 0.25 -0.5 0.625 -0.125 1.0 0.375.
			32'hbf40_0000, 32'h3fc0_0000, 32'h3e80_0000, 32'hbf00_0000,
			32'h3f20_0000, 32'hbe00_0000, 32'h3f80_0000, 32'h3ec0_0000
		},
		{ // 1.25 0.5 -1.0 0.25 0.75 -0.375 -0.25 1.5.
			32'h3fa0_0000, 32'h3f00_0000, 32'hbf80_0000, 32'h3e80_0000,
			32'h3f40_0000, 32'hbec0_0000, 32'hbe80_0000, 32'h3fc0_0000
		},
		{ // -0.25 -0.625 0.5 1.0 0.25 1.25 -0.75 0.5.
			32'hbe80_0000, 32'hbf20_0000, 32'h3f00_0000, 32'h3f80_0000,
			32'h3e80_0000, 32'h3fa0_0000, 32'hbf40_0000, 32'h3f00_0000
		}
	};

	// 0.25 -0.5 0.125 -0.25.
	localparam logic [0:hiddenCount-1][31:0] hiddenBias = {
		32'h3e80_0000, 32'hbf00_0000, 32'h3e00_0000, 32'hbe80_0000
	};

	localparam logic [0:outCount-1][0:hiddenCount-1][31:0] outWeight = {
		{ // 0.75 -0.5 1.25 -0.375.
			32'h3f40_0000, 32'hbf00_0000, 32'h3fa0_0000, 32'hbec0_0000
		},
		{ // -1.0 0.625 0.25 1.5.
			32'hbf80_0000, 32'h3f20_0000, 32'h3e80_0000, 32'h3fc0_0000
		}
	};

	// 0.5 -0.125.
	localparam logic [0:outCount-1][31:0] outBias = {
		32'h3f00_0000, 32'hbe00_0000
	};

endpackage
